// File: flist.f
glbPkg.sv
glbReqIf.sv
glbBank.sv
glbBankArray.sv
glbWrCtrl.sv
glbRdCtrl.sv
glbTop.sv
glbChecker.sv
tbGlb.sv

// File: glbBank.sv
// Single-port SRAM bank model with registered read data; one instance per bank
`timescale 1ns/10ps
`default_nettype none

module glbBank (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         we,
    input  logic [glbPkg::RowWidth-1:0]  row,
    input  logic [glbPkg::DataWidth-1:0] wdata,
    output logic [glbPkg::DataWidth-1:0] rdata
);
    import glbPkg::*;

    logic [DataWidth-1:0] mem [BankDepth];

    // One access per cycle, either write or read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[row] <= wdata;
            end else begin
                rdata <= mem[row];
            end
        end
    end

endmodule

`default_nettype wire

// File: glbBankArray.sv
// Bank array that arbitrates both requests and steers read data; instantiated by the top level
`timescale 1ns/10ps
`default_nettype none

module glbBankArray (
    input  logic    clk,
    input  logic    rst_n,
    glbReqIf.wrBank wrReq,
    glbReqIf.rdBank rdReq
);
    import glbPkg::*;

    logic [BankIdxWidth-1:0] wrBankIdx;
    logic [BankIdxWidth-1:0] rdBankIdx;
    logic [RowWidth-1:0]     wrRow;
    logic [RowWidth-1:0]     rdRow;
    logic                    conflict;
    logic [BankIdxWidth-1:0] rdBankQ;
    logic [DataWidth-1:0]    bankRdata [NumBank];

    // ========================================================================
    // Address decode and arbitration
    // ========================================================================
    assign wrBankIdx = wrReq.addr.split.bankIdx;
    assign wrRow     = wrReq.addr.split.row;
    assign rdBankIdx = rdReq.addr.split.bankIdx;
    assign rdRow     = rdReq.addr.split.row;

    // A read on the same single-port bank blocks the write
    assign conflict  = rdReq.req & (rdBankIdx == wrBankIdx);
    assign wrReq.gnt = ~conflict;
    assign rdReq.gnt = rdReq.req;

    // ========================================================================
    // Banks
    // ========================================================================
    for (genvar b = 0; b < NumBank; b++) begin : g_bank
        logic                rdSel;
        logic                wrSel;
        logic                bankEn;
        logic                bankWe;
        logic [RowWidth-1:0] bankRow;

        assign rdSel = rdReq.req & (rdBankIdx == BankIdxWidth'(b));
        assign wrSel = wrReq.req & wrReq.gnt & (wrBankIdx == BankIdxWidth'(b));

        // Read owns the port when both hit this bank
        assign bankEn  = rdSel | wrSel;
        assign bankWe  = ~rdSel;
        assign bankRow = rdSel ? rdRow : wrRow;

        glbBank i_bank (
            .clk   (clk),
            .en    (bankEn),
            .we    (bankWe),
            .row   (bankRow),
            .wdata (wrReq.data),
            .rdata (bankRdata[b])
        );
    end

    // ========================================================================
    // Read data steering
    // ========================================================================
    // Bank of the last granted read, used in its return cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdBankQ <= '0;
        end else if (rdReq.req & rdReq.gnt) begin
            rdBankQ <= rdBankIdx;
        end
    end

    assign rdReq.data = bankRdata[rdBankQ];

endmodule

`default_nettype wire

// File: glbChecker.sv
// Testbench checker for the global buffer; watches the DUT ports and compares them with a model
`timescale 1ns/10ps
`default_nettype none

module glbChecker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfgVld,
    input  logic [glbPkg::PtrWidth-1:0]  cfgAddrMax,
    input  logic [glbPkg::DataWidth-1:0] wrDat,
    input  logic                         wrDatVld,
    input  logic                         wrDatRdy,
    input  logic                         wrFull,
    input  logic [glbPkg::PtrWidth-1:0]  wrReqNum,
    input  logic                         rdDatRdy,
    input  logic [glbPkg::DataWidth-1:0] rdDat,
    input  logic                         rdDatVld,
    input  logic                         rdEmpty,
    input  logic [glbPkg::PtrWidth-1:0]  rdReqNum,
    output int                           errCount,
    output int                           readCount
);
    import glbPkg::*;

    // Model state with the words in write order
    logic [DataWidth-1:0] model [$];
    logic [PtrWidth-1:0]  capM;
    logic [PtrWidth-1:0]  wrPtrM;
    logic [PtrWidth-1:0]  rdPtrM;
    logic                 pendVld;
    logic [DataWidth-1:0] pendDat;
    int                   errors = 0;
    int                   reads = 0;

    assign errCount  = errors;
    assign readCount = reads;

    // Bank holding a pointer position is given by the address bits above the row
    function automatic int bankOf(input logic [PtrWidth-1:0] ptr);
        return (int'(ptr) % (NumBank * BankDepth)) / BankDepth;
    endfunction

    // Expected handshake and status for the coming edge
    function automatic void predict(
        input  int                  fill,
        input  logic [PtrWidth-1:0] cap,
        input  logic                sameBank,
        input  logic                cfg,
        input  logic                rdAsk,
        output logic                expRdy,
        output logic                expIssue,
        output logic                expFull,
        output logic                expEmpty,
        output logic [PtrWidth-1:0] expWrNum,
        output logic [PtrWidth-1:0] expRdNum
    );
        expFull  = (fill == int'(cap));
        expEmpty = (fill == 0);
        expIssue = rdAsk && !expEmpty && !cfg;
        // Read takes the single port of a shared bank
        expRdy   = !expFull && !(expIssue && sameBank);
        expWrNum = cap - PtrWidth'(fill);
        expRdNum = PtrWidth'(fill);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // ========================================================================
    // Compare at the falling edge, then step the model over the next edge
    // ========================================================================
    always @(negedge clk) begin : compare
        int                  fill;
        logic                expRdy;
        logic                expIssue;
        logic                expFull;
        logic                expEmpty;
        logic [PtrWidth-1:0] expWrNum;
        logic [PtrWidth-1:0] expRdNum;
        logic                wrAccept;
        if (!rst_n) begin
            model.delete();
            capM    = '0;
            wrPtrM  = '0;
            rdPtrM  = '0;
            pendVld = 1'b0;
        end
        fill = model.size();
        predict(fill, capM, bankOf(wrPtrM) == bankOf(rdPtrM), cfgVld, rdDatRdy,
                expRdy, expIssue, expFull, expEmpty, expWrNum, expRdNum);
        checkValue("wrDatRdy", 32'(expRdy), 32'(wrDatRdy));
        checkValue("wrFull", 32'(expFull), 32'(wrFull));
        checkValue("rdEmpty", 32'(expEmpty), 32'(rdEmpty));
        checkValue("wrReqNum", 32'(expWrNum), 32'(wrReqNum));
        checkValue("rdReqNum", 32'(expRdNum), 32'(rdReqNum));
        checkValue("rdDatVld", 32'(pendVld), 32'(rdDatVld));
        if (pendVld) begin
            checkValue("rdDat", pendDat, rdDat);
            reads++;
        end
        if (rst_n) begin
            wrAccept = wrDatVld && expRdy && !cfgVld;
            pendVld  = expIssue;
            if (cfgVld) begin
                capM   = cfgAddrMax;
                wrPtrM = '0;
                rdPtrM = '0;
                model.delete();
            end else begin
                if (expIssue) begin
                    pendDat = model.pop_front();
                    rdPtrM  = rdPtrM + PtrWidth'(1);
                end
                if (wrAccept) begin
                    model.push_back(wrDat);
                    wrPtrM = wrPtrM + PtrWidth'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: glbPkg.sv
// Buffer sizes and address types shared by every unit of the banked global buffer
`default_nettype none

package glbPkg;

    // ========================================================================
    // Buffer geometry
    // ========================================================================
    localparam int DataWidth    = 32;
    localparam int NumBank      = 4;
    localparam int BankDepth    = 16;

    // Row inside one bank, and the bank select above it
    localparam int RowWidth     = 4;
    localparam int BankIdxWidth = 2;

    // Flat address over all 64 words of the banks
    localparam int BufAddrWidth = 6;

    // Extra top bit so a full buffer and an empty one differ
    localparam int PtrWidth     = 7;

    // ========================================================================
    // Bank address decoding
    // ========================================================================

    // Split view with the bank index on top and the row within the bank below
    typedef struct packed {
        logic [BankIdxWidth-1:0] bankIdx;
        logic [RowWidth-1:0]     row;
    } glbBankAddr_s;

    // Controllers write the flat view and the bank array reads the split view.
    // Taking the low bits as row is the same as subtracting bankIdx * BankDepth
    typedef union packed {
        logic [BufAddrWidth-1:0] flat;
        glbBankAddr_s            split;
    } glbAddr_u;

endpackage

`default_nettype wire

// File: glbRdCtrl.sv
// Read side of the buffer with read pointer, empty flag and fill level; instantiated by the top
`timescale 1ns/10ps
`default_nettype none

module glbRdCtrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfgVld,
    input  logic                         rdDatRdy,
    input  logic [glbPkg::PtrWidth-1:0]  wrPtr,
    glbReqIf.reader                      rdReq,
    output logic [glbPkg::DataWidth-1:0] rdDat,
    output logic                         rdDatVld,
    output logic                         rdEmpty,
    output logic [glbPkg::PtrWidth-1:0]  rdReqNum,
    output logic [glbPkg::PtrWidth-1:0]  rdPtr
);
    import glbPkg::*;

    logic [PtrWidth-1:0] fill;
    logic                rdFire;

    // ========================================================================
    // Status and request
    // ========================================================================
    assign fill     = wrPtr - rdPtr;
    assign rdEmpty  = (fill == '0);
    assign rdReqNum = fill;

    // No read in the configuration cycle
    assign rdReq.req       = rdDatRdy & ~rdEmpty & ~cfgVld;
    assign rdReq.addr.flat = rdPtr[BufAddrWidth-1:0];

    // Granted request moves the pointer
    assign rdFire = rdReq.req & rdReq.gnt;

    // ========================================================================
    // Read pointer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPtr <= '0;
        end else if (cfgVld) begin
            rdPtr <= '0;
        end else if (rdFire) begin
            rdPtr <= rdPtr + PtrWidth'(1);
        end
    end

    // ========================================================================
    // Returned data
    // ========================================================================
    // Bank read is registered, so valid trails the grant by one cycle.
    // A new read may issue while the previous one returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdDatVld <= 1'b0;
        end else begin
            rdDatVld <= rdFire;
        end
    end

    // Data already steered to the right bank by the array
    assign rdDat = rdReq.data;

endmodule

`default_nettype wire

// File: glbReqIf.sv
// One bank request between a pointer controller and the bank array; instantiate once per port
`timescale 1ns/10ps
`default_nettype none

interface glbReqIf;
    import glbPkg::*;

    // Done at the edge where req and gnt are both high
    logic                 req;
    glbAddr_u             addr;
    // Write payload, or read data one cycle after the grant
    logic [DataWidth-1:0] data;
    logic                 gnt;

    // Controller side
    modport writer (output req, output addr, output data, input gnt);
    modport reader (output req, output addr, input data, input gnt);

    // Bank array side
    modport wrBank (input req, input addr, input data, output gnt);
    modport rdBank (input req, input addr, output data, output gnt);

endinterface

`default_nettype wire

// File: glbTop.sv
// Top level of the banked global buffer; plain ports for configuration, write and read traffic
`timescale 1ns/10ps
`default_nettype none

module glbTop (
    input  logic                         clk,
    input  logic                         rst_n,

    // Configuration strobe
    input  logic                         cfgVld,
    input  logic [glbPkg::PtrWidth-1:0]  cfgAddrMax,

    // Write port
    input  logic [glbPkg::DataWidth-1:0] wrDat,
    input  logic                         wrDatVld,
    output logic                         wrDatRdy,
    output logic                         wrFull,
    output logic [glbPkg::PtrWidth-1:0]  wrReqNum,

    // Read port
    input  logic                         rdDatRdy,
    output logic [glbPkg::DataWidth-1:0] rdDat,
    output logic                         rdDatVld,
    output logic                         rdEmpty,
    output logic [glbPkg::PtrWidth-1:0]  rdReqNum
);
    import glbPkg::*;

    // Pointers exchanged between the controllers
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;

    glbReqIf wrReq ();
    glbReqIf rdReq ();

    // ========================================================================
    // Controllers
    // ========================================================================
    glbWrCtrl i_wrCtrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfgVld     (cfgVld),
        .cfgAddrMax (cfgAddrMax),
        .wrDat      (wrDat),
        .wrDatVld   (wrDatVld),
        .rdPtr      (rdPtr),
        .wrReq      (wrReq.writer),
        .wrDatRdy   (wrDatRdy),
        .wrFull     (wrFull),
        .wrReqNum   (wrReqNum),
        .wrPtr      (wrPtr)
    );

    glbRdCtrl i_rdCtrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfgVld   (cfgVld),
        .rdDatRdy (rdDatRdy),
        .wrPtr    (wrPtr),
        .rdReq    (rdReq.reader),
        .rdDat    (rdDat),
        .rdDatVld (rdDatVld),
        .rdEmpty  (rdEmpty),
        .rdReqNum (rdReqNum),
        .rdPtr    (rdPtr)
    );

    // ========================================================================
    // Banks
    // ========================================================================
    glbBankArray i_bankArray (
        .clk   (clk),
        .rst_n (rst_n),
        .wrReq (wrReq.wrBank),
        .rdReq (rdReq.rdBank)
    );

endmodule

`default_nettype wire

// File: glbWrCtrl.sv
// Write side of the buffer with capacity, write pointer and full flag; instantiated by the top
`timescale 1ns/10ps
`default_nettype none

module glbWrCtrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfgVld,
    input  logic [glbPkg::PtrWidth-1:0]  cfgAddrMax,
    input  logic [glbPkg::DataWidth-1:0] wrDat,
    input  logic                         wrDatVld,
    input  logic [glbPkg::PtrWidth-1:0]  rdPtr,
    glbReqIf.writer                      wrReq,
    output logic                         wrDatRdy,
    output logic                         wrFull,
    output logic [glbPkg::PtrWidth-1:0]  wrReqNum,
    output logic [glbPkg::PtrWidth-1:0]  wrPtr
);
    import glbPkg::*;

    logic [PtrWidth-1:0] capacity;
    logic [PtrWidth-1:0] fill;
    logic                wrFire;

    // ========================================================================
    // Capacity and write pointer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capacity <= '0;
        end else if (cfgVld) begin
            capacity <= cfgAddrMax;
        end
    end

    assign wrFire = wrReq.req & wrReq.gnt;

    // Configuration restarts the buffer and wins over a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
        end else if (cfgVld) begin
            wrPtr <= '0;
        end else if (wrFire) begin
            wrPtr <= wrPtr + PtrWidth'(1);
        end
    end

    // ========================================================================
    // Status
    // ========================================================================
    // Modulo difference stays valid across pointer wrap
    assign fill     = wrPtr - rdPtr;
    assign wrFull   = (fill == capacity);
    assign wrReqNum = capacity - fill;

    // Request toward the bank array
    assign wrReq.req       = wrDatVld & ~wrFull & ~cfgVld;
    assign wrReq.addr.flat = wrPtr[BufAddrWidth-1:0];
    assign wrReq.data      = wrDat;

    // Low on full or when a read holds the same bank
    assign wrDatRdy = ~wrFull & wrReq.gnt;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Compile the global buffer testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --timescale 1ns/10ps -f flist.f \
    --top-module tbGlb --Mdir "$BUILD" -o simGlb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/simGlb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tbGlb.sv
// Testbench top for the global buffer; clock, reset, random traffic phases and the final report
`timescale 1ns/10ps
`default_nettype none

module tbGlb;
    import glbPkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 cfgVld;
    logic [PtrWidth-1:0]  cfgAddrMax;
    logic [DataWidth-1:0] wrDat;
    logic                 wrDatVld;
    logic                 wrDatRdy;
    logic                 wrFull;
    logic [PtrWidth-1:0]  wrReqNum;
    logic                 rdDatRdy;
    logic [DataWidth-1:0] rdDat;
    logic                 rdDatVld;
    logic                 rdEmpty;
    logic [PtrWidth-1:0]  rdReqNum;

    int          checkErrors;
    int          wordsChecked;
    int          stalls;
    int          readsIssued;
    int          wrDensity;
    int          rdDensity;
    int          cfgCapNext;
    int          newCaps [3];
    logic        cfgNext;
    logic        seenFull;
    logic        seenEmpty;
    logic [31:0] lfsr;

    glbTop i_dut (.*);

    glbChecker i_checker (.*, .errCount(checkErrors), .readCount(wordsChecked));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Sample at the falling edge and drive at the rising edge
    task automatic stepCycle();
        logic        wrTaken;
        logic [31:0] r;
        @(negedge clk);
        wrTaken   = wrDatVld && wrDatRdy && !cfgVld;
        seenFull  = wrFull;
        seenEmpty = rdEmpty;
        if (rdDatRdy && !rdEmpty && !cfgVld) begin
            readsIssued++;
        end
        @(posedge clk);
        cfgVld     <= cfgNext;
        cfgAddrMax <= PtrWidth'(cfgCapNext);
        cfgNext    = 1'b0;
        // A refused word stays on the bus unchanged
        if (!wrDatVld || wrTaken) begin
            takeBits(4, r);
            if (int'(r[3:0]) < wrDensity) begin
                takeBits(32, r);
                wrDat    <= r;
                wrDatVld <= 1'b1;
            end else begin
                wrDatVld <= 1'b0;
            end
        end
        takeBits(4, r);
        rdDatRdy <= (int'(r[3:0]) < rdDensity);
    endtask

    // Strobe lasts one cycle while traffic keeps running
    task automatic configure(input int cap);
        cfgNext    = 1'b1;
        cfgCapNext = cap;
        stepCycle();
        stepCycle();
    endtask

    function automatic logic goalReached(input string goal, input int target);
        if (goal == "full") begin
            return seenFull;
        end
        if (goal == "empty") begin
            return seenEmpty;
        end
        return readsIssued >= target;
    endfunction

    task automatic runUntil(input string goal, input int target, input int limit);
        int n;
        n         = 0;
        seenFull  = 1'b0;
        seenEmpty = 1'b0;
        while (!goalReached(goal, target) && n < limit) begin
            stepCycle();
            n++;
        end
        if (!goalReached(goal, target)) begin
            $display("Stall at %0t: goal '%s' not reached within %0d cycles", $time, goal, limit);
            stalls++;
        end
    endtask

    // ========================================================================
    // Test phases
    // ========================================================================
    initial begin
        lfsr        = 32'h045b332d;
        stalls      = 0;
        readsIssued = 0;
        cfgNext     = 1'b0;
        cfgCapNext  = 0;
        newCaps     = '{37, 5, 64};
        rst_n       = 1'b0;
        cfgVld      = 1'b0;
        cfgAddrMax  = '0;
        wrDat       = '0;
        wrDatVld    = 1'b0;
        rdDatRdy    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Capacity is zero out of reset so every write is refused
        wrDensity = 16;
        rdDensity = 16;
        repeat (4) stepCycle();

        configure(64);
        wrDensity = 12;
        rdDensity = 10;
        runUntil("reads", readsIssued + 150, 3000);

        wrDensity = 16;
        rdDensity = 0;
        runUntil("full", 0, 400);
        repeat (6) stepCycle();

        // Keep asking after the last word is gone
        wrDensity = 0;
        rdDensity = 16;
        runUntil("empty", 0, 400);
        repeat (6) stepCycle();

        // Small capacity so the pointers wrap many times
        configure(10);
        wrDensity = 10;
        rdDensity = 8;
        runUntil("reads", readsIssued + 200, 3000);

        wrDensity = 12;
        rdDensity = 12;
        for (int i = 0; i < 3; i++) begin
            runUntil("reads", readsIssued + 40, 1000);
            configure(newCaps[i]);
        end
        runUntil("reads", readsIssued + 60, 2000);

        wrDensity = 0;
        rdDensity = 16;
        runUntil("empty", 0, 400);
        repeat (3) stepCycle();

        $display("Errors: %0d mismatches, %0d stalls, %0d words checked",
                 checkErrors, stalls, wordsChecked);
        if (checkErrors == 0 && stalls == 0 && wordsChecked > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
